/* common/view_pkg.sv */
package view_pkg;

	// screen geometry
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int X_W = 9;
	localparam int Y_W = 8;

	localparam int COLOR_W = 12;

	// sprite geometry with transparent corner squares
	localparam int SPRITE_SIZE = 16;
	localparam int SPRITE_W = $clog2(SPRITE_SIZE);
	localparam int CORNER = 2;

	// object map
	localparam int OBJ_COUNT = 8;
	localparam int OBJ_IDX_W = 3;
	localparam logic [OBJ_IDX_W-1:0] OBJ_LAST = OBJ_IDX_W'(OBJ_COUNT - 1);

	typedef enum logic [1:0] {
		KIND_GOLD = 2'd0,
		KIND_STONE = 2'd1,
		KIND_DIAMOND = 2'd2
	} obj_kind_t;

	// palette where zero stands for transparent
	localparam logic [COLOR_W-1:0] BG_COLOR = 12'h852;
	localparam logic [COLOR_W-1:0] GOLD_COLOR = 12'hfd0;
	localparam logic [COLOR_W-1:0] STONE_COLOR = 12'h888;
	localparam logic [COLOR_W-1:0] DIAMOND_COLOR = 12'h0ff;

	// game progress
	localparam int LEVEL_W = 3;
	localparam int SCORE_W = 10;
	localparam int GOAL_W = 12;
	localparam logic [GOAL_W-1:0] GOAL_BASE = 12'd75;
	localparam logic [GOAL_W-1:0] GOAL_STEP = 12'd75;

	// countdown in frames
	localparam int TIME_W = 8;
	localparam logic [TIME_W-1:0] TIME_START = 8'd20;

endpackage

/* draw/rect_raster.sv */
`timescale 1ns/1ps

module rect_raster #(
	parameter int WIDTH = 16,
	parameter int HEIGHT = 16
) (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	output logic [$clog2(WIDTH)-1:0] col,
	output logic [$clog2(HEIGHT)-1:0] row,
	output logic valid,
	output logic done
);

	localparam int COL_W = $clog2(WIDTH);
	localparam int ROW_W = $clog2(HEIGHT);

	logic busy;
	logic last_col;
	logic last_row;

	assign last_col = (col == COL_W'(WIDTH - 1));
	assign last_row = (row == ROW_W'(HEIGHT - 1));
	assign valid = busy;

	// left to right, then next row down
	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (busy) begin
				if (last_col) begin
					col <= '0;
					if (last_row) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

/* draw/draw_sequencer.sv */
`timescale 1ns/1ps

module draw_sequencer (
	input  logic clk,
	input  logic resetn,
	input  logic go,
	input  logic game_over,
	input  logic bg_done,
	input  logic sprite_done,
	output logic bg_start,
	output logic sprite_start,
	output logic [view_pkg::OBJ_IDX_W-1:0] obj_index,
	output logic frame_end
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BG,
		S_FETCH,
		S_SPRITE,
		S_END
	} state_t;

	state_t state;
	logic last_obj;

	assign last_obj = (obj_index == view_pkg::OBJ_LAST);

	// game_progress sees this while the last sprite finishes,
	// so game_over is already settled when S_END decides
	assign frame_end = (state == S_SPRITE) && sprite_done && last_obj;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			bg_start <= 1'b0;
			sprite_start <= 1'b0;
			obj_index <= '0;
		end else begin
			bg_start <= 1'b0;
			sprite_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go) begin
						state <= S_BG;
						bg_start <= 1'b1;
						obj_index <= '0;
					end
				end
				S_BG: begin
					if (bg_done)
						state <= S_FETCH;
				end
				S_FETCH: begin
					// map entry lands at the end of this cycle
					state <= S_SPRITE;
					sprite_start <= 1'b1;
				end
				S_SPRITE: begin
					if (sprite_done) begin
						if (last_obj) begin
							state <= S_END;
						end else begin
							// invisible entries are walked too
							obj_index <= obj_index + 1'b1;
							state <= S_FETCH;
						end
					end
				end
				S_END: begin
					if (game_over) begin
						state <= S_IDLE;
					end else begin
						state <= S_BG;
						bg_start <= 1'b1;
						obj_index <= '0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* draw/pixel_painter.sv */
`timescale 1ns/1ps

module pixel_painter (
	input  logic clk,
	input  logic resetn,
	input  logic bg_valid,
	input  logic [view_pkg::X_W-1:0] bg_col,
	input  logic [view_pkg::Y_W-1:0] bg_row,
	input  logic sprite_valid,
	input  logic [view_pkg::SPRITE_W-1:0] sprite_col,
	input  logic [view_pkg::SPRITE_W-1:0] sprite_row,
	input  logic [view_pkg::X_W-1:0] obj_x,
	input  logic [view_pkg::Y_W-1:0] obj_y,
	input  view_pkg::obj_kind_t obj_kind,
	input  logic obj_visible,
	output logic [view_pkg::X_W-1:0] x,
	output logic [view_pkg::Y_W-1:0] y,
	output logic [view_pkg::COLOR_W-1:0] color,
	output logic write_en
);

	localparam int SPRITE_W = view_pkg::SPRITE_W;
	localparam int HI_EDGE = view_pkg::SPRITE_SIZE - view_pkg::CORNER;

	logic [view_pkg::X_W-1:0] sprite_dx;
	logic [view_pkg::Y_W-1:0] sprite_dy;
	logic col_edge;
	logic row_edge;
	logic [view_pkg::COLOR_W-1:0] kind_color;
	logic [view_pkg::X_W-1:0] x_next;
	logic [view_pkg::Y_W-1:0] y_next;
	logic [view_pkg::COLOR_W-1:0] color_next;
	logic we_next;

	assign sprite_dx = {{(view_pkg::X_W - SPRITE_W){1'b0}}, sprite_col};
	assign sprite_dy = {{(view_pkg::Y_W - SPRITE_W){1'b0}}, sprite_row};

	// corner square when both offsets sit near an edge
	assign col_edge = (sprite_col < SPRITE_W'(view_pkg::CORNER)) ||
		(sprite_col >= SPRITE_W'(HI_EDGE));
	assign row_edge = (sprite_row < SPRITE_W'(view_pkg::CORNER)) ||
		(sprite_row >= SPRITE_W'(HI_EDGE));

	always_comb begin
		case (obj_kind)
			view_pkg::KIND_GOLD: kind_color = view_pkg::GOLD_COLOR;
			view_pkg::KIND_STONE: kind_color = view_pkg::STONE_COLOR;
			view_pkg::KIND_DIAMOND: kind_color = view_pkg::DIAMOND_COLOR;
			default: kind_color = '0;
		endcase
	end

	always_comb begin
		x_next = bg_col;
		y_next = bg_row;
		color_next = view_pkg::BG_COLOR;
		we_next = bg_valid;
		if (sprite_valid) begin
			x_next = obj_x + sprite_dx;
			y_next = obj_y + sprite_dy;
			color_next = (col_edge && row_edge) ? '0 : kind_color;
			// colour zero is see-through
			we_next = obj_visible && (color_next != '0);
		end
	end

	always_ff @(posedge clk) begin
		x <= x_next;
		y <= y_next;
		color <= color_next;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			write_en <= 1'b0;
		else
			write_en <= we_next;
	end

endmodule

/* logic/map_rom.sv */
`timescale 1ns/1ps

module map_rom (
	input  logic clk,
	input  logic [view_pkg::OBJ_IDX_W-1:0] obj_index,
	output logic [view_pkg::X_W-1:0] obj_x,
	output logic [view_pkg::Y_W-1:0] obj_y,
	output view_pkg::obj_kind_t obj_kind,
	output logic obj_visible
);

	// entry is ready one cycle after the address
	// origins keep every box fully on screen
	always_ff @(posedge clk) begin
		case (obj_index)
			3'd0: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd40, 8'd60, view_pkg::KIND_GOLD, 1'b1};
			3'd1: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd100, 8'd120, view_pkg::KIND_STONE, 1'b1};
			3'd2: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd200, 8'd80, view_pkg::KIND_DIAMOND, 1'b1};
			// already grabbed
			3'd3: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd260, 8'd150, view_pkg::KIND_GOLD, 1'b0};
			3'd4: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd20, 8'd200, view_pkg::KIND_STONE, 1'b1};
			3'd5: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd150, 8'd180, view_pkg::KIND_GOLD, 1'b1};
			// already grabbed
			3'd6: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd290, 8'd100, view_pkg::KIND_DIAMOND, 1'b0};
			default: {obj_x, obj_y, obj_kind, obj_visible} <=
				{9'd180, 8'd210, view_pkg::KIND_STONE, 1'b1};
		endcase
	end

endmodule

/* logic/game_progress.sv */
`timescale 1ns/1ps

module game_progress (
	input  logic clk,
	input  logic resetn,
	input  logic go,
	input  logic frame_end,
	input  logic [view_pkg::SCORE_W-1:0] score,
	output logic [view_pkg::LEVEL_W-1:0] level,
	output logic [view_pkg::TIME_W-1:0] time_left,
	output logic game_over
);

	logic [view_pkg::GOAL_W-1:0] level_ext;
	logic [view_pkg::GOAL_W-1:0] score_ext;
	logic [view_pkg::GOAL_W-1:0] goal;
	logic goal_met;

	assign level_ext = {{(view_pkg::GOAL_W - view_pkg::LEVEL_W){1'b0}}, level};
	assign score_ext = {{(view_pkg::GOAL_W - view_pkg::SCORE_W){1'b0}}, score};

	// goal grows by one step per level
	assign goal = view_pkg::GOAL_BASE + view_pkg::GOAL_STEP * level_ext;
	assign goal_met = (score_ext >= goal);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			level <= '0;
			time_left <= view_pkg::TIME_START;
			game_over <= 1'b0;
		end else if (go) begin
			// fresh game
			level <= '0;
			time_left <= view_pkg::TIME_START;
			game_over <= 1'b0;
		end else if (frame_end && !game_over) begin
			if (goal_met) begin
				level <= level + 1'b1;
				time_left <= view_pkg::TIME_START;
			end else begin
				time_left <= time_left - 1'b1;
				// last tick ends the game
				if (time_left == view_pkg::TIME_W'(1))
					game_over <= 1'b1;
			end
		end
	end

endmodule

/* logic/view_top.sv */
`timescale 1ns/1ps

module view_top (
	input  logic clk,
	input  logic resetn,
	input  logic go,
	input  logic [view_pkg::SCORE_W-1:0] score,
	output logic [view_pkg::X_W-1:0] x,
	output logic [view_pkg::Y_W-1:0] y,
	output logic [view_pkg::COLOR_W-1:0] color,
	output logic write_en,
	output logic [view_pkg::LEVEL_W-1:0] level,
	output logic [view_pkg::TIME_W-1:0] time_left,
	output logic game_over
);

	logic bg_start;
	logic bg_done;
	logic bg_valid;
	logic [view_pkg::X_W-1:0] bg_col;
	logic [view_pkg::Y_W-1:0] bg_row;

	logic sprite_start;
	logic sprite_done;
	logic sprite_valid;
	logic [view_pkg::SPRITE_W-1:0] sprite_col;
	logic [view_pkg::SPRITE_W-1:0] sprite_row;

	logic [view_pkg::OBJ_IDX_W-1:0] obj_index;
	logic [view_pkg::X_W-1:0] obj_x;
	logic [view_pkg::Y_W-1:0] obj_y;
	view_pkg::obj_kind_t obj_kind;
	logic obj_visible;

	logic frame_end;

	draw_sequencer u_sequencer (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.game_over(game_over),
		.bg_done(bg_done),
		.sprite_done(sprite_done),
		.bg_start(bg_start),
		.sprite_start(sprite_start),
		.obj_index(obj_index),
		.frame_end(frame_end)
	);

	// full screen background pass
	rect_raster #(
		.WIDTH(view_pkg::SCREEN_W),
		.HEIGHT(view_pkg::SCREEN_H)
	) bg_raster (
		.clk(clk),
		.resetn(resetn),
		.start(bg_start),
		.col(bg_col),
		.row(bg_row),
		.valid(bg_valid),
		.done(bg_done)
	);

	// one sprite box per map entry
	rect_raster #(
		.WIDTH(view_pkg::SPRITE_SIZE),
		.HEIGHT(view_pkg::SPRITE_SIZE)
	) sprite_raster (
		.clk(clk),
		.resetn(resetn),
		.start(sprite_start),
		.col(sprite_col),
		.row(sprite_row),
		.valid(sprite_valid),
		.done(sprite_done)
	);

	map_rom u_map (
		.clk(clk),
		.obj_index(obj_index),
		.obj_x(obj_x),
		.obj_y(obj_y),
		.obj_kind(obj_kind),
		.obj_visible(obj_visible)
	);

	pixel_painter u_painter (
		.clk(clk),
		.resetn(resetn),
		.bg_valid(bg_valid),
		.bg_col(bg_col),
		.bg_row(bg_row),
		.sprite_valid(sprite_valid),
		.sprite_col(sprite_col),
		.sprite_row(sprite_row),
		.obj_x(obj_x),
		.obj_y(obj_y),
		.obj_kind(obj_kind),
		.obj_visible(obj_visible),
		.x(x),
		.y(y),
		.color(color),
		.write_en(write_en)
	);

	game_progress u_progress (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.frame_end(frame_end),
		.score(score),
		.level(level),
		.time_left(time_left),
		.game_over(game_over)
	);

endmodule

/* dv/view_properties.sv */
`timescale 1ns/1ps

module view_properties (
	input  logic clk,
	input  logic resetn,
	input  logic write_en,
	input  logic [view_pkg::X_W-1:0] x,
	input  logic [view_pkg::Y_W-1:0] y,
	input  logic [view_pkg::COLOR_W-1:0] color
);

	// write_en is cleared by the first reset edge
	no_write_in_reset: assert property (
		@(posedge clk) !resetn |=> !write_en
	) else $error("write_en high while resetn is low");

	// every write lands on the screen
	write_in_range: assert property (
		@(posedge clk) disable iff (!resetn)
		write_en |-> (x < view_pkg::SCREEN_W) && (y < view_pkg::SCREEN_H)
	) else $error("pixel write outside the screen");

	// transparent pixels never reach the frame buffer
	write_not_clear: assert property (
		@(posedge clk) disable iff (!resetn)
		write_en |-> (color != '0)
	) else $error("pixel write with colour zero");

endmodule

/* dv/view_tb.sv */
`timescale 1ns/1ps

module view_tb;

	localparam string STIM_FILE = "dv/view_stim.txt";
	localparam logic [31:0] SEED = 32'd45929;
	localparam int WRITE_TIMEOUT = 1000;
	localparam int PROGRESS_TIMEOUT = 100;
	localparam int IDLE_WATCH = 2000;
	localparam logic [11:0] RANDOM_SCORE = 12'hfff;
	localparam int SPRITE_WRITES = view_pkg::SPRITE_SIZE * view_pkg::SPRITE_SIZE -
		4 * view_pkg::CORNER * view_pkg::CORNER;

	logic clk;
	logic resetn;
	logic go;
	logic [view_pkg::SCORE_W-1:0] score;
	logic [view_pkg::X_W-1:0] x;
	logic [view_pkg::Y_W-1:0] y;
	logic [view_pkg::COLOR_W-1:0] color;
	logic write_en;
	logic [view_pkg::LEVEL_W-1:0] level;
	logic [view_pkg::TIME_W-1:0] time_left;
	logic game_over;

	logic [27:0] stim_mem [0:31];
	int map_x [view_pkg::OBJ_COUNT];
	int map_y [view_pkg::OBJ_COUNT];
	int map_kind [view_pkg::OBJ_COUNT];
	bit map_vis [view_pkg::OBJ_COUNT];
	logic [31:0] lcg_state;
	int write_count;

	view_top DUT (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.score(score),
		.x(x),
		.y(y),
		.color(color),
		.write_en(write_en),
		.level(level),
		.time_left(time_left),
		.game_over(game_over)
	);

	bind pixel_painter view_properties u_props (
		.clk(clk),
		.resetn(resetn),
		.write_en(write_en),
		.x(x),
		.y(y),
		.color(color)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// pixel writes seen so far
	always @(negedge clk) begin
		if (!resetn)
			write_count <= 0;
		else if (write_en === 1'b1)
			write_count <= write_count + 1;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [view_pkg::COLOR_W-1:0] kind_color(int kind);
		case (kind)
			0: return view_pkg::GOLD_COLOR;
			1: return view_pkg::STONE_COLOR;
			2: return view_pkg::DIAMOND_COLOR;
			default: return '0;
		endcase
	endfunction

	// corner squares of the sprite box stay transparent
	function automatic bit in_corner(int c, int r);
		bit c_edge;
		bit r_edge;
		c_edge = (c < view_pkg::CORNER) || (c >= view_pkg::SPRITE_SIZE - view_pkg::CORNER);
		r_edge = (r < view_pkg::CORNER) || (r >= view_pkg::SPRITE_SIZE - view_pkg::CORNER);
		return c_edge && r_edge;
	endfunction

	task automatic fail_run(string what);
		$display("%s at %0t ns", what, $time);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_write();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (write_en !== 1'b1) begin
			cycles++;
			if (cycles > WRITE_TIMEOUT)
				fail_run("no pixel write arrived in time");
			@(negedge clk);
		end
	endtask

	task automatic expect_pixel(int ex, int ey, logic [view_pkg::COLOR_W-1:0] ec);
		wait_write();
		check_value("x", x, ex);
		check_value("y", y, ey);
		check_value("color", color, ec);
	endtask

	// background in raster order, then each visible sprite minus corners
	task automatic verify_frame();
		for (int r = 0; r < view_pkg::SCREEN_H; r++) begin
			for (int c = 0; c < view_pkg::SCREEN_W; c++)
				expect_pixel(c, r, view_pkg::BG_COLOR);
		end
		for (int i = 0; i < view_pkg::OBJ_COUNT; i++) begin
			if (map_vis[i]) begin
				for (int r = 0; r < view_pkg::SPRITE_SIZE; r++) begin
					for (int c = 0; c < view_pkg::SPRITE_SIZE; c++) begin
						if (!in_corner(c, r))
							expect_pixel(map_x[i] + c, map_y[i] + r, kind_color(map_kind[i]));
					end
				end
			end
		end
	endtask

	// frame end always moves either level or time_left
	task automatic await_progress(int old_level, int old_time);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (level == old_level && time_left == old_time) begin
			check_value("write_en", write_en, 0);
			cycles++;
			if (cycles > PROGRESS_TIMEOUT)
				fail_run("level and time_left did not update after the frame");
			@(negedge clk);
		end
	endtask

	initial begin
		int line;
		int rep_count;
		int goal;
		int frame_score;
		int exp_level;
		int exp_time;
		int exp_over;
		int prev_level;
		int prev_time;
		int frame_writes;
		int first_write;
		bit started;
		logic [11:0] stim_score;

		resetn = 1'b0;
		go = 1'b0;
		score = '0;
		lcg_state = SEED;
		started = 1'b0;
		$readmemh(STIM_FILE, stim_mem);
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		// idle until go
		repeat (20) begin
			@(negedge clk);
			check_value("write_en", write_en, 0);
		end
		check_value("level", level, 0);
		check_value("time_left", time_left, view_pkg::TIME_START);
		check_value("game_over", game_over, 0);

		// whole background plus the visible sprites
		frame_writes = view_pkg::SCREEN_W * view_pkg::SCREEN_H;
		for (int i = 0; i < view_pkg::OBJ_COUNT; i++) begin
			map_x[i] = stim_mem[i][27:16];
			map_y[i] = stim_mem[i][15:8];
			map_kind[i] = stim_mem[i][7:4];
			map_vis[i] = stim_mem[i][0];
			if (map_vis[i])
				frame_writes += SPRITE_WRITES;
		end

		exp_level = 0;
		exp_time = view_pkg::TIME_START;
		exp_over = 0;
		line = view_pkg::OBJ_COUNT;
		while (stim_mem[line][15:8] != 0) begin
			stim_score = stim_mem[line][27:16];
			rep_count = stim_mem[line][15:8];
			for (int n = 0; n < rep_count; n++) begin
				goal = int'(view_pkg::GOAL_BASE) + int'(view_pkg::GOAL_STEP) * exp_level;
				if (stim_score == RANDOM_SCORE) begin
					lcg_state = lcg_next(lcg_state);
					frame_score = int'(lcg_state[23:8]) % goal;
				end else begin
					frame_score = stim_score;
				end
				@(posedge clk);
				score <= frame_score[view_pkg::SCORE_W-1:0];
				first_write = write_count;
				if (!started) begin
					go <= 1'b1;
					started = 1'b1;
					@(posedge clk);
					go <= 1'b0;
				end
				prev_level = exp_level;
				prev_time = exp_time;
				verify_frame();
				if (frame_score >= goal) begin
					exp_level++;
					exp_time = view_pkg::TIME_START;
				end else begin
					exp_time--;
					if (exp_time == 0)
						exp_over = 1;
				end
				await_progress(prev_level, prev_time);
				check_value("level", level, exp_level);
				check_value("time_left", time_left, exp_time);
				check_value("game_over", game_over, exp_over);
				@(posedge clk);
				check_value("write count", write_count - first_write, frame_writes);
			end
			check_value("level", level, stim_mem[line][7:0]);
			line++;
		end
		check_value("game_over", game_over, 1);

		// drawing stops after game over
		repeat (IDLE_WATCH) begin
			@(negedge clk);
			check_value("write_en", write_en, 0);
		end

		// a new go restarts the game from level 0
		@(posedge clk);
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		@(negedge clk);
		check_value("level", level, 0);
		check_value("time_left", time_left, view_pkg::TIME_START);
		check_value("game_over", game_over, 0);
		expect_pixel(0, 0, view_pkg::BG_COLOR);

		$display("All tests passed");
		$finish;
	end

endmodule

/* dv/view_stim.txt */
// map rows: x(3 hex) _ y(2 hex) _ kind _ visible, one per object index
// frame rows: score(3 hex, fff = random below goal) _ frame count _ level after, 000_00_00 ends
028_3c_0_1
064_78_1_1
0c8_50_2_1
104_96_0_0
014_c8_1_1
096_b4_0_1
122_64_2_0
0b4_d2_1_1
// first goal met exactly
04b_01_01
fff_01_01
// level 1 goal met
096_01_02
// run the clock down to game over
fff_14_02
000_00_00

/* verilog.f */
common/view_pkg.sv
draw/rect_raster.sv
draw/draw_sequencer.sv
draw/pixel_painter.sv
logic/map_rom.sv
logic/game_progress.sv
logic/view_top.sv
dv/view_properties.sv
dv/view_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module view_tb -o view_sim

sim_out=$(./obj_dir/view_sim || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "All tests passed"; then
	exit 0
else
	exit 1
fi
